// ==== sigmoidPkg.sv ====
package sigmoidPkg;

    // one activation or result code
    localparam int codeWidth = 8;

    typedef logic [codeWidth-1:0] codeT;

    // results per RES row
    localparam int resColumns = 2;

    // SIG row is bias then two activations
    localparam int sigColumns = 3;

    // constant written to SIG column 0
    localparam codeT biasCode = codeT'(255);

    // column index inside one SIG row
    typedef logic [1:0] colT;

endpackage

// ==== sigCmdIf.sv ====
`timescale 1ns/1ps

interface sigCmdIf #(
    parameter int rowCount = 64
);

    localparam int rowBits = $clog2(rowCount);

    // one command per cycle, no stall path
    logic cmdValid;
    logic [rowBits-1:0] row;
    sigmoidPkg::colT col;
    logic last;

    modport sequencer (
        output cmdValid,
        output row,
        output col,
        output last
    );

    modport writer (
        input cmdValid,
        input row,
        input col,
        input last
    );

endinterface

// ==== sigmoidLut.sv ====
`timescale 1ns/1ps

module sigmoidLut (
    input  sigmoidPkg::codeT code,
    output sigmoidPkg::codeT activation
);

    // output for the lowest inputs
    localparam sigmoidPkg::codeT floorCode = sigmoidPkg::codeT'(12);
    localparam int stepCount = 231;

    // entry k is the first input whose output exceeds floorCode + k
    // repeated entries mark output codes the curve skips
    localparam sigmoidPkg::codeT thresholds [stepCount] = '{
        // outputs 12 to 21
        8'd4,   8'd7,   8'd10,  8'd13,  8'd16,  8'd18,  8'd21,  8'd23,  8'd25,  8'd28,
        8'd30,  8'd32,  8'd34,  8'd35,  8'd37,  8'd39,  8'd41,  8'd42,  8'd44,  8'd45,
        8'd47,  8'd48,  8'd50,  8'd51,  8'd53,  8'd54,  8'd55,  8'd57,  8'd58,  8'd59,
        8'd60,  8'd61,  8'd63,  8'd64,  8'd65,  8'd66,  8'd67,  8'd68,  8'd69,  8'd70,
        8'd71,  8'd72,  8'd73,  8'd74,  8'd75,  8'd76,  8'd77,  8'd78,  8'd79,  8'd80,
        8'd81,  8'd82,  8'd83,  8'd83,  8'd84,  8'd85,  8'd86,  8'd87,  8'd88,  8'd88,
        8'd89,  8'd90,  8'd91,  8'd92,  8'd93,  8'd93,  8'd94,  8'd95,  8'd96,  8'd96,
        8'd97,  8'd98,  8'd99,  8'd99,  8'd100, 8'd101, 8'd102, 8'd102, 8'd103, 8'd104,
        // steep middle of the curve, mostly two codes per input step
        8'd105, 8'd105, 8'd106, 8'd107, 8'd107, 8'd108, 8'd109, 8'd110, 8'd110, 8'd111,
        8'd112, 8'd112, 8'd113, 8'd114, 8'd114, 8'd115, 8'd116, 8'd116, 8'd117, 8'd118,
        8'd118, 8'd119, 8'd120, 8'd120, 8'd121, 8'd122, 8'd122, 8'd123, 8'd124, 8'd124,
        8'd125, 8'd126, 8'd126, 8'd127, 8'd128, 8'd128, 8'd129, 8'd130, 8'd131, 8'd131,
        8'd132, 8'd133, 8'd133, 8'd134, 8'd135, 8'd135, 8'd136, 8'd137, 8'd137, 8'd138,
        8'd139, 8'd139, 8'd140, 8'd141, 8'd141, 8'd142, 8'd143, 8'd143, 8'd144, 8'd145,
        8'd145, 8'd146, 8'd147, 8'd147, 8'd148, 8'd149, 8'd150, 8'd150, 8'd151, 8'd152,
        8'd152, 8'd153, 8'd154, 8'd155, 8'd155, 8'd156, 8'd157, 8'd158, 8'd158, 8'd159,
        8'd160, 8'd161, 8'd161, 8'd162, 8'd163, 8'd164, 8'd164, 8'd165, 8'd166, 8'd167,
        8'd168, 8'd169, 8'd169, 8'd170, 8'd171, 8'd172, 8'd173, 8'd174, 8'd174, 8'd175,
        // outputs 192 to 201, input 177 now maps to 194
        8'd176, 8'd177, 8'd178, 8'd179, 8'd180, 8'd181, 8'd182, 8'd183, 8'd184, 8'd185,
        8'd186, 8'd187, 8'd188, 8'd189, 8'd190, 8'd191, 8'd192, 8'd193, 8'd194, 8'd196,
        8'd197, 8'd198, 8'd199, 8'd200, 8'd202, 8'd203, 8'd204, 8'd206, 8'd207, 8'd209,
        8'd210, 8'd212, 8'd213, 8'd215, 8'd216, 8'd218, 8'd220, 8'd222, 8'd223, 8'd225,
        8'd227, 8'd229, 8'd232, 8'd234, 8'd236, 8'd239, 8'd241, 8'd244, 8'd247, 8'd250,
        // 253 and above saturate at 243
        8'd253
    };

    // thresholds ascend, so the last one passed sets the output
    always_comb begin
        activation = floorCode;
        for (int k = 0; k < stepCount; k++) begin
            if (code >= thresholds[k]) begin
                activation = sigmoidPkg::codeT'(floorCode + k + 1);
            end
        end
    end

endmodule

// ==== rowSequencer.sv ====
`timescale 1ns/1ps

module rowSequencer #(
    parameter int rowCount = 64
) (
    input  logic clk,
    input  logic arstN,
    input  logic startSigmoid,
    output logic resReadEn,
    output logic [$clog2(rowCount * sigmoidPkg::resColumns)-1:0] resReadAddress,
    sigCmdIf.sequencer cmd
);

    localparam int rowBits = $clog2(rowCount);
    localparam int resAddrBits = $clog2(rowCount * sigmoidPkg::resColumns);
    localparam sigmoidPkg::colT lastCol = sigmoidPkg::colT'(sigmoidPkg::sigColumns - 1);
    localparam logic [rowBits-1:0] lastRow = rowBits'(rowCount - 1);

    logic busy;
    logic [rowBits-1:0] rowCnt;
    sigmoidPkg::colT colCnt;
    logic rowDone;
    logic runDone;

    assign rowDone = (colCnt == lastCol);
    assign runDone = rowDone && (rowCnt == lastRow);

    // idle waits for start, busy walks rows and columns
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy   <= 1'b0;
            rowCnt <= '0;
            colCnt <= '0;
        end else if (!busy) begin
            if (startSigmoid) begin
                busy   <= 1'b1;
                rowCnt <= '0;
                colCnt <= '0;
            end
        end else if (rowDone) begin
            colCnt <= '0;
            if (runDone) begin
                busy <= 1'b0;
            end else begin
                rowCnt <= rowCnt + 1'b1;
            end
        end else begin
            colCnt <= colCnt + 1'b1;
        end
    end

    // one command every busy cycle
    assign cmd.cmdValid = busy;
    assign cmd.row      = rowCnt;
    assign cmd.col      = colCnt;
    assign cmd.last     = busy && runDone;

    // fetch RES entries with the bias and first activation commands
    // so each lands one cycle later for the activation columns
    assign resReadEn      = busy && !rowDone;
    assign resReadAddress = resAddrBits'(rowCnt * sigmoidPkg::resColumns + colCnt);

endmodule

// ==== sigWriter.sv ====
`timescale 1ns/1ps

module sigWriter #(
    parameter int rowCount = 64
) (
    input  logic clk,
    input  logic arstN,
    sigCmdIf.writer cmd,
    input  sigmoidPkg::codeT resReadData,
    output logic sigWriteEn,
    output logic [$clog2(rowCount * sigmoidPkg::sigColumns)-1:0] sigWriteAddress,
    output sigmoidPkg::codeT sigWriteData,
    output logic endSigmoid
);

    localparam int sigAddrBits = $clog2(rowCount * sigmoidPkg::sigColumns);

    sigmoidPkg::codeT activation;
    logic lastQ;

    sigmoidLut i_sigmoidLut (
        .code       (resReadData),
        .activation (activation)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sigWriteEn <= 1'b0;
            lastQ      <= 1'b0;
            endSigmoid <= 1'b0;
        end else begin
            sigWriteEn <= cmd.cmdValid;
            lastQ      <= cmd.cmdValid && cmd.last;
            // done follows the final write by one cycle
            endSigmoid <= lastQ;
        end
    end

    // column 0 is the bias, the others take the lookup
    always_ff @(posedge clk) begin
        if (cmd.cmdValid) begin
            sigWriteAddress <= sigAddrBits'(cmd.row * sigmoidPkg::sigColumns + cmd.col);
            sigWriteData    <= (cmd.col == '0) ? sigmoidPkg::biasCode : activation;
        end
    end

endmodule

// ==== sigmoidTop.sv ====
`timescale 1ns/1ps

module sigmoidTop #(
    parameter int rowCount = 64
) (
    input  logic clk,
    input  logic arstN,
    input  logic startSigmoid,
    output logic endSigmoid,
    output logic resReadEn,
    output logic [$clog2(rowCount * sigmoidPkg::resColumns)-1:0] resReadAddress,
    input  sigmoidPkg::codeT resReadData,
    output logic sigWriteEn,
    output logic [$clog2(rowCount * sigmoidPkg::sigColumns)-1:0] sigWriteAddress,
    output sigmoidPkg::codeT sigWriteData
);

    // sequencer to writer command path
    sigCmdIf #(
        .rowCount (rowCount)
    ) i_cmdIf ();

    rowSequencer #(
        .rowCount (rowCount)
    ) i_rowSequencer (
        .clk            (clk),
        .arstN          (arstN),
        .startSigmoid   (startSigmoid),
        .resReadEn      (resReadEn),
        .resReadAddress (resReadAddress),
        .cmd            (i_cmdIf.sequencer)
    );

    sigWriter #(
        .rowCount (rowCount)
    ) i_sigWriter (
        .clk             (clk),
        .arstN           (arstN),
        .cmd             (i_cmdIf.writer),
        .resReadData     (resReadData),
        .sigWriteEn      (sigWriteEn),
        .sigWriteAddress (sigWriteAddress),
        .sigWriteData    (sigWriteData),
        .endSigmoid      (endSigmoid)
    );

endmodule

// ==== sigmoidTop_props.sv ====
`timescale 1ns/1ps

module sigmoidTopProps (
    input logic clk,
    input logic arstN,
    input logic endSigmoid,
    input logic resReadEn,
    input logic sigWriteEn
);

    // read by the testbench for its verdict
    int assertFails = 0;

    // done is a one-cycle pulse
    endSingleCycle: assert property (
        @(posedge clk) disable iff (!arstN) endSigmoid |=> !endSigmoid
    ) else begin
        assertFails++;
        $error("endSigmoid stayed high for two cycles");
    end

    // done comes after the last write, never with it
    writeNotWithEnd: assert property (
        @(posedge clk) disable iff (!arstN) !(sigWriteEn && endSigmoid)
    ) else begin
        assertFails++;
        $error("sigWriteEn and endSigmoid high in the same cycle");
    end

    quietInReset: assert property (
        @(posedge clk) !arstN |-> !(resReadEn || sigWriteEn || endSigmoid)
    ) else begin
        assertFails++;
        $error("enable output high while arstN is low");
    end

endmodule

bind sigmoidTop sigmoidTopProps i_sigmoidTopProps (
    .clk        (clk),
    .arstN      (arstN),
    .endSigmoid (endSigmoid),
    .resReadEn  (resReadEn),
    .sigWriteEn (sigWriteEn)
);

// ==== sigmoidChecker.sv ====
`timescale 1ns/1ps

module sigmoidChecker #(
    parameter int rowCount = 64
) (
    input  logic clk,
    input  logic arstN,
    input  logic startSigmoid,
    input  logic endSigmoid,
    input  logic resReadEn,
    input  logic [$clog2(rowCount * sigmoidPkg::resColumns)-1:0] resReadAddress,
    input  sigmoidPkg::codeT resReadData,
    input  logic sigWriteEn,
    input  logic [$clog2(rowCount * sigmoidPkg::sigColumns)-1:0] sigWriteAddress,
    input  sigmoidPkg::codeT sigWriteData,
    output int errorCount,
    output int runCount,
    output int writeTotal
);

    localparam int readsPerRun = rowCount * sigmoidPkg::resColumns;
    localparam int writesPerRun = rowCount * sigmoidPkg::sigColumns;
    // done is sampled two cycles after the final command
    localparam int doneCycle = writesPerRun + 2;

    int errors = 0;
    int runs = 0;
    int writesAll = 0;

    bit running = 1'b0;
    int cycle;
    int writeCount;
    int readCount;
    int lastWriteCycle;
    bit readPending = 1'b0;
    int pendingAddr;

    // RES entries as seen on the read port during this run
    sigmoidPkg::codeT shadow [readsPerRun];
    bit shadowValid [readsPerRun];

    assign errorCount = errors;
    assign runCount   = runs;
    assign writeTotal = writesAll;

    // logistic curve scaled to 8 bits, rounded to nearest
    function automatic int sigmoidRef(input int x);
        real e;
        e = $exp(-3.0 * (x - 128) / 128.0);
        return $rtoi(255.0 / (1.0 + e) + 0.5);
    endfunction

    task automatic beginRun();
        running = 1'b1;
        cycle = 0;
        writeCount = 0;
        readCount = 0;
        lastWriteCycle = -1;
        for (int i = 0; i < readsPerRun; i++) begin
            shadowValid[i] = 1'b0;
        end
    endtask

    task automatic checkWrite();
        int addr;
        int row;
        int col;
        int entry;
        int expected;
        int tol;
        int diff;
        addr = sigWriteAddress;
        if (addr != writeCount) begin
            errors++;
            $display("mismatch at %0t: sigWriteAddress expected %0d got %0d",
                     $time, writeCount, addr);
        end
        row = addr / sigmoidPkg::sigColumns;
        col = addr % sigmoidPkg::sigColumns;
        tol = 0;
        // bias column
        expected = 255;
        if (col != 0) begin
            entry = row * sigmoidPkg::resColumns + col - 1;
            if (entry >= readsPerRun || !shadowValid[entry]) begin
                errors++;
                $display("write to SIG address %0d at %0t came before RES entry %0d was read",
                         addr, $time, entry);
                expected = -1;
            end else begin
                expected = sigmoidRef(shadow[entry]);
                // table ends must be exact
                tol = (shadow[entry] == 0 || shadow[entry] == 255) ? 0 : 1;
            end
        end
        if (expected >= 0) begin
            diff = int'(sigWriteData) - expected;
            if (diff < 0) begin
                diff = -diff;
            end
            if (diff > tol) begin
                errors++;
                $display("mismatch at %0t: sigWriteData[%0d] expected %0d got %0d",
                         $time, addr, expected, sigWriteData);
            end
        end
        writeCount++;
        writesAll++;
        lastWriteCycle = cycle;
    endtask

    task automatic closeRun();
        if (writeCount != writesPerRun) begin
            errors++;
            $display("mismatch at %0t: write count expected %0d got %0d",
                     $time, writesPerRun, writeCount);
        end
        if (readCount != readsPerRun) begin
            errors++;
            $display("mismatch at %0t: resReadEn count expected %0d got %0d",
                     $time, readsPerRun, readCount);
        end
        if (cycle != doneCycle || lastWriteCycle != cycle - 1) begin
            errors++;
            $display("mismatch at %0t: endSigmoid cycle expected %0d got %0d (last write %0d)",
                     $time, doneCycle, cycle, lastWriteCycle);
        end
        running = 1'b0;
        runs++;
    endtask

    always @(posedge clk) begin
        if (!arstN) begin
            running = 1'b0;
            readPending = 1'b0;
        end else begin
            // data from last cycle's read is on the port now
            if (readPending) begin
                shadow[pendingAddr] = resReadData;
                shadowValid[pendingAddr] = 1'b1;
                readPending = 1'b0;
            end
            if (running) begin
                cycle++;
                if (resReadEn) begin
                    if (resReadAddress != readCount) begin
                        errors++;
                        $display("mismatch at %0t: resReadAddress expected %0d got %0d",
                                 $time, readCount, resReadAddress);
                    end
                    readPending = 1'b1;
                    pendingAddr = resReadAddress;
                    readCount++;
                end
                if (sigWriteEn) begin
                    checkWrite();
                end
                if (endSigmoid) begin
                    closeRun();
                end
            end else begin
                if (resReadEn || sigWriteEn || endSigmoid) begin
                    errors++;
                    $display("enable output high at %0t with no run in progress", $time);
                end
                if (startSigmoid) begin
                    beginRun();
                end
            end
        end
    end

endmodule

// ==== tbSigmoid.sv ====
`timescale 1ns/1ps

module tbSigmoid;

    localparam int rowCount = 64;
    localparam int resDepth = rowCount * sigmoidPkg::resColumns;
    localparam int resAddrBits = $clog2(resDepth);
    localparam int sigAddrBits = $clog2(rowCount * sigmoidPkg::sigColumns);
    localparam int doneTimeout = 400;
    localparam int expectedRuns = 2;

    logic clk;
    logic arstN;
    logic startSigmoid;
    logic endSigmoid;
    logic resReadEn;
    logic [resAddrBits-1:0] resReadAddress;
    sigmoidPkg::codeT resReadData = '0;
    logic sigWriteEn;
    logic [sigAddrBits-1:0] sigWriteAddress;
    sigmoidPkg::codeT sigWriteData;

    sigmoidPkg::codeT resMem [resDepth];
    integer seed;
    int tbErrors;
    bit timedOut;
    int checkErrors;
    int runsSeen;
    int writesSeen;
    int assertFails;
    int totalErrors;

    sigmoidTop #(
        .rowCount (rowCount)
    ) i_sigmoidTop (
        .clk             (clk),
        .arstN           (arstN),
        .startSigmoid    (startSigmoid),
        .endSigmoid      (endSigmoid),
        .resReadEn       (resReadEn),
        .resReadAddress  (resReadAddress),
        .resReadData     (resReadData),
        .sigWriteEn      (sigWriteEn),
        .sigWriteAddress (sigWriteAddress),
        .sigWriteData    (sigWriteData)
    );

    sigmoidChecker #(
        .rowCount (rowCount)
    ) i_sigmoidChecker (
        .clk             (clk),
        .arstN           (arstN),
        .startSigmoid    (startSigmoid),
        .endSigmoid      (endSigmoid),
        .resReadEn       (resReadEn),
        .resReadAddress  (resReadAddress),
        .resReadData     (resReadData),
        .sigWriteEn      (sigWriteEn),
        .sigWriteAddress (sigWriteAddress),
        .sigWriteData    (sigWriteData),
        .errorCount      (checkErrors),
        .runCount        (runsSeen),
        .writeTotal      (writesSeen)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RES memory with a one-cycle synchronous read
    always @(posedge clk) begin
        if (resReadEn) begin
            resReadData <= resMem[resReadAddress];
        end
    end

    task automatic fillRes();
        for (int i = 0; i < resDepth; i++) begin
            resMem[i] = sigmoidPkg::codeT'($random(seed));
        end
        // both table ends, the midpoint and the corrected entry
        resMem[0] = 8'd0;
        resMem[1] = 8'd255;
        resMem[2] = 8'd128;
        resMem[3] = 8'd177;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulseStart();
        @(negedge clk);
        startSigmoid = 1'b1;
        @(negedge clk);
        startSigmoid = 1'b0;
    endtask

    task automatic waitForDone(input string what);
        int waited;
        waited = 0;
        while (endSigmoid !== 1'b1 && waited < doneTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (endSigmoid !== 1'b1) begin
            timedOut = 1'b1;
            $display("timeout: no endSigmoid within %0d cycles during the %s",
                     doneTimeout, what);
        end else begin
            @(negedge clk);
        end
    endtask

    initial begin
        seed = 25;
        tbErrors = 0;
        timedOut = 1'b0;
        arstN = 1'b1;
        startSigmoid = 1'b0;
        fillRes();
        #1;
        arstN = 1'b0;

        repeat (16) @(negedge clk);
        arstN = 1'b1;

        // idle outputs are watched by the checker
        idleCycles(8);

        // a second start in the middle must be ignored
        pulseStart();
        idleCycles(60);
        pulseStart();
        waitForDone("first run");

        if (!timedOut) begin
            fillRes();
            idleCycles(4);
            pulseStart();
            waitForDone("second run");
        end
        idleCycles(4);

        if (!timedOut && runsSeen != expectedRuns) begin
            tbErrors++;
            $display("expected %0d completed runs but the checker saw %0d",
                     expectedRuns, runsSeen);
        end

        assertFails = i_sigmoidTop.i_sigmoidTopProps.assertFails;
        totalErrors = checkErrors + assertFails + tbErrors;
        $write("summary: runs %0d, writes %0d, checker errors %0d, ",
               runsSeen, writesSeen, checkErrors);
        $display("assertion failures %0d, testbench errors %0d", assertFails, tbErrors);
        if (!timedOut && totalErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
sigmoidPkg.sv
sigCmdIf.sv
sigmoidLut.sv
rowSequencer.sv
sigWriter.sv
sigmoidTop.sv
sigmoidTop_props.sv
sigmoidChecker.sv
tbSigmoid.sv
